/* fetch_sys.f */
design/fetch_pkg.sv
design/instr_mem.sv
design/icache.sv
design/fetch_unit.sv
design/fetch_top.sv
tb/fetch_top_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_top_tb \
    -f fetch_sys.f -o fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && { echo 'simulation failed'; exit 1; }
grep -q 'All tests passed!' sim.log || { echo 'simulation ended without a result'; exit 1; }
echo 'simulation passed'

/* tb/fetch_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top_tb;

    localparam int PROG_BITS = 8;
    localparam int PROG_WORDS = 2 ** PROG_BITS; // loaded range, holds every pc the table touches
    localparam int NUM_ROWS = 9;
    localparam int CYCLES_PER_FETCH = fetch_pkg::MEM_LATENCY + 8; // generous bound for one miss

    // one column per field, one entry per row
    localparam logic [fetch_pkg::ADDR_BITS-1:0] ROW_START [NUM_ROWS] = '{
        16'h0000, 16'h0000, 16'h0025, 16'h0035, 16'h0025,
        16'h0035, 16'h0000, 16'h0040, 16'h0080
    };
    localparam int ROW_COUNT [NUM_ROWS] = '{16, 16, 1, 1, 1, 1, 16, 2, 2};
    localparam bit ROW_FLUSH [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0};
    localparam int ROW_HITS [NUM_ROWS] = '{0, 16, 0, 0, 0, 0, 0, 0, 2};
    localparam int ROW_MISSES [NUM_ROWS] = '{16, 0, 1, 1, 1, 1, 16, 3, 0};
    localparam bit ROW_MID [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};
    localparam logic [fetch_pkg::ADDR_BITS-1:0] ROW_MID_PC [NUM_ROWS] = '{
        16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0000, 16'h0000, 16'h0080, 16'h0000
    };

    logic clk;
    logic rst;
    logic run;
    logic flush;
    logic redirect_valid;
    logic load_valid;
    logic [fetch_pkg::ADDR_BITS-1:0] redirect_pc;
    logic [fetch_pkg::ADDR_BITS-1:0] load_addr;
    logic [fetch_pkg::DATA_BITS-1:0] load_data;
    logic instr_valid;
    logic [fetch_pkg::ADDR_BITS-1:0] instr_pc;
    logic [fetch_pkg::DATA_BITS-1:0] instr_data;
    logic [fetch_pkg::COUNT_BITS-1:0] hit_count;
    logic [fetch_pkg::COUNT_BITS-1:0] miss_count;

    logic [fetch_pkg::DATA_BITS-1:0] model [PROG_WORDS]; // what the instruction memory should hold
    logic [31:0] rng_state;
    int hits_total; // hits the counter should have reached so far
    int misses_total;

    fetch_top u_fetch_top (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .load_valid     (load_valid),
        .redirect_pc    (redirect_pc),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            stop_run($sformatf("error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    // outputs are registered, so one ns after the edge they are settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet(input int cycles);
        int i;
        for (i = 0; i < cycles; i++)
        begin
            next_cycle();
            check_value("instr_valid", 32'(instr_valid), 32'h0);
        end
    endtask

    task automatic load_program();
        int a;
        logic [PROG_BITS-1:0] idx;
        for (a = 0; a < PROG_WORDS; a++)
        begin
            idx = PROG_BITS'(a);
            rng_state = lcg_next(rng_state);
            model[idx] = rng_state;
            load_valid = 1'b1;
            load_addr = fetch_pkg::ADDR_BITS'(a);
            load_data = rng_state;
            next_cycle();
        end
        load_valid = 1'b0;
    endtask

    task automatic run_row(input int row);
        logic [fetch_pkg::ADDR_BITS-1:0] expect_pc;
        int seen;
        int cycles;
        int limit;
        if (ROW_FLUSH[row])
        begin
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            load_program(); // fresh words so stale lines would show up as wrong data
        end
        redirect_valid = 1'b1;
        redirect_pc = ROW_START[row];
        next_cycle();
        redirect_valid = 1'b0;
        run = 1'b1;
        expect_pc = ROW_MID[row] ? ROW_MID_PC[row] : ROW_START[row];
        seen = 0;
        cycles = 0;
        limit = (ROW_COUNT[row] + 2) * CYCLES_PER_FETCH;
        while ((seen < ROW_COUNT[row]) && (cycles < limit))
        begin
            next_cycle();
            cycles++;
            redirect_valid = 1'b0;
            if (instr_valid)
            begin
                check_value("instr_pc", 32'(instr_pc), 32'(expect_pc));
                check_value("instr_data", instr_data, model[expect_pc[PROG_BITS-1:0]]);
                expect_pc = expect_pc + 1'b1;
                seen++;
            end
            if (ROW_MID[row] && (cycles == 2))
            begin
                redirect_valid = 1'b1; // lands while the first miss is still in flight
                redirect_pc = ROW_MID_PC[row];
            end
            // one request is always in flight, so stop issuing one instruction early
            if (seen >= ROW_COUNT[row] - 1)
            begin
                run = 1'b0;
            end
        end
        run = 1'b0;
        if (seen < ROW_COUNT[row])
        begin
            stop_run($sformatf("timeout in row %0d: only %0d of %0d instructions arrived",
                               row, seen, ROW_COUNT[row]));
        end
        check_quiet(4);
        hits_total += ROW_HITS[row];
        misses_total += ROW_MISSES[row];
        check_value("hit_count", 32'(hit_count), 32'(hits_total));
        check_value("miss_count", 32'(miss_count), 32'(misses_total));
    endtask

    initial
    begin
        int row;
        rst = 1'b1;
        run = 1'b0;
        flush = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        load_valid = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng_state = 32'd64498;
        hits_total = 0;
        misses_total = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_quiet(4);
        check_value("hit_count", 32'(hit_count), 32'h0);
        check_value("miss_count", 32'(miss_count), 32'h0);
        load_program();
        check_value("instr_valid", 32'(instr_valid), 32'h0);
        check_value("hit_count", 32'(hit_count), 32'h0);
        check_value("miss_count", 32'(miss_count), 32'h0);
        for (row = 0; row < NUM_ROWS; row++)
        begin
            run_row(row);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             run,
    input  wire logic                             flush,
    input  wire logic                             redirect_valid,
    input  wire logic                             load_valid,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0]  redirect_pc,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0]  load_addr,
    input  wire logic [fetch_pkg::DATA_BITS-1:0]  load_data,
    output logic                                  instr_valid,
    output logic      [fetch_pkg::ADDR_BITS-1:0]  instr_pc,
    output logic      [fetch_pkg::DATA_BITS-1:0]  instr_data,
    output logic      [fetch_pkg::COUNT_BITS-1:0] hit_count,
    output logic      [fetch_pkg::COUNT_BITS-1:0] miss_count
);

    logic cpu_req_valid;
    logic [fetch_pkg::ADDR_BITS-1:0] cpu_req_addr;
    logic cpu_req_ready;
    logic [fetch_pkg::DATA_BITS-1:0] cpu_req_data;

    logic mem_req_valid;
    logic [fetch_pkg::ADDR_BITS-1:0] mem_req_addr;
    logic mem_req_ready;
    logic [fetch_pkg::DATA_BITS-1:0] mem_req_data;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_data   (cpu_req_data),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data)
    );

    icache u_icache (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    instr_mem u_instr_mem (
        .clk           (clk),
        .rst           (rst),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            run,
    input  wire logic                            redirect_valid,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0] redirect_pc,
    output logic                                 cpu_req_valid,
    output logic      [fetch_pkg::ADDR_BITS-1:0] cpu_req_addr,
    input  wire logic                            cpu_req_ready,
    input  wire logic [fetch_pkg::DATA_BITS-1:0] cpu_req_data,
    output logic                                 instr_valid,
    output logic      [fetch_pkg::ADDR_BITS-1:0] instr_pc,
    output logic      [fetch_pkg::DATA_BITS-1:0] instr_data
);

    logic [fetch_pkg::ADDR_BITS-1:0] pc; // next address to request
    logic [fetch_pkg::ADDR_BITS-1:0] req_addr; // address of the outstanding request
    logic [fetch_pkg::ADDR_BITS-1:0] issue_addr;
    logic busy;
    logic drop; // outstanding response belongs to a pc left by a redirect
    logic waiting;
    logic issue;

    assign waiting = busy && !cpu_req_ready;
    assign issue = run && !waiting; // a new request goes out alongside a ready pulse
    assign issue_addr = redirect_valid ? redirect_pc : pc;

    assign cpu_req_valid = waiting || issue;
    assign cpu_req_addr = waiting ? req_addr : issue_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
            busy <= 1'b0;
            drop <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            instr_valid <= cpu_req_ready && !drop && !redirect_valid;
            if (issue)
            begin
                busy <= 1'b1;
                pc <= issue_addr + 1'b1; // wraps at the address width
                drop <= 1'b0;
            end
            else
            begin
                if (cpu_req_ready)
                begin
                    busy <= 1'b0;
                end
                if (redirect_valid)
                begin
                    pc <= redirect_pc;
                    drop <= waiting;
                end
                else if (cpu_req_ready)
                begin
                    drop <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            req_addr <= issue_addr;
        end
        if (cpu_req_ready)
        begin
            instr_pc <= req_addr;
            instr_data <= cpu_req_data;
        end
    end

    // the cache may still be looking at the address until it answers
    assert property (@(posedge clk) disable iff (rst)
        (cpu_req_valid && !cpu_req_ready) ##1 (cpu_req_valid && !cpu_req_ready)
        |-> $stable(cpu_req_addr));

endmodule

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ns
`default_nettype none

module icache (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             flush,
    input  wire logic                             cpu_req_valid,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0]  cpu_req_addr,
    output logic                                  cpu_req_ready,
    output logic      [fetch_pkg::DATA_BITS-1:0]  cpu_req_data,
    output logic                                  mem_req_valid,
    output logic      [fetch_pkg::ADDR_BITS-1:0]  mem_req_addr,
    input  wire logic                             mem_req_ready,
    input  wire logic [fetch_pkg::DATA_BITS-1:0]  mem_req_data,
    output logic      [fetch_pkg::COUNT_BITS-1:0] hit_count,
    output logic      [fetch_pkg::COUNT_BITS-1:0] miss_count
);

    fetch_pkg::cache_state_t state;
    fetch_pkg::cache_state_t next_state;

    logic [fetch_pkg::ADDR_BITS-1:0] req_addr; // address taken at the last acceptance
    logic [fetch_pkg::NUM_LINES-1:0] valid_bits;
    logic [fetch_pkg::TAG_BITS-1:0] tag_array [fetch_pkg::NUM_LINES];
    logic [fetch_pkg::DATA_BITS-1:0] data_array [fetch_pkg::NUM_LINES];

    logic [fetch_pkg::INDEX_BITS-1:0] idx;
    logic [fetch_pkg::TAG_BITS-1:0] tag;
    logic hit;
    logic miss;
    logic accept;
    logic fill;
    logic refill; // the next ready pulse follows a line fill

    assign idx = req_addr[fetch_pkg::INDEX_BITS-1:0];
    assign tag = req_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::INDEX_BITS];

    assign hit = (state == fetch_pkg::COMPARE_TAG) && valid_bits[idx] && (tag_array[idx] == tag);
    assign miss = (state == fetch_pkg::COMPARE_TAG) && !hit;
    assign fill = (state == fetch_pkg::ALLOCATE) && mem_req_ready;

    // a new address is taken in IDLE or alongside a hit
    assign accept = cpu_req_valid && ((state == fetch_pkg::IDLE) || hit);

    assign cpu_req_ready = hit;
    assign cpu_req_data = data_array[idx];
    assign mem_req_addr = req_addr; // held steady through ALLOCATE

    always_comb
    begin
        next_state = state;
        case (state)
            fetch_pkg::IDLE:
            begin
                if (accept)
                begin
                    next_state = fetch_pkg::COMPARE_TAG;
                end
            end
            fetch_pkg::COMPARE_TAG:
            begin
                if (!hit)
                begin
                    next_state = fetch_pkg::ALLOCATE;
                end
                else if (!accept)
                begin
                    next_state = fetch_pkg::IDLE;
                end
            end
            fetch_pkg::ALLOCATE:
            begin
                if (mem_req_ready)
                begin
                    next_state = fetch_pkg::COMPARE_TAG; // compare again and hit on the new line
                end
            end
            default:
            begin
                next_state = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= fetch_pkg::IDLE;
            valid_bits <= '0;
            mem_req_valid <= 1'b0;
            refill <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (flush)
            begin
                valid_bits <= '0;
            end
            else if (fill)
            begin
                valid_bits[idx] <= 1'b1;
            end
            if (miss)
            begin
                mem_req_valid <= 1'b1;
            end
            else if (mem_req_ready)
            begin
                mem_req_valid <= 1'b0;
            end
            if (fill)
            begin
                refill <= 1'b1;
            end
            else if (hit)
            begin
                refill <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr <= cpu_req_addr;
        end
        if (fill)
        begin
            tag_array[idx] <= tag;
            data_array[idx] <= mem_req_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count <= '0;
            miss_count <= '0;
        end
        else
        begin
            if (hit && !refill && (hit_count != '1))
            begin
                hit_count <= hit_count + 1'b1;
            end
            if (miss && (miss_count != '1))
            begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // the memory request may only be open while the line fill is in progress
    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (state == fetch_pkg::ALLOCATE));

    // invalidating lines under an outstanding request would corrupt the fill
    assert property (@(posedge clk) disable iff (rst)
        flush |-> (state == fetch_pkg::IDLE));

endmodule

`default_nettype wire

/* design/instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_mem (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            load_valid,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0] load_addr,
    input  wire logic [fetch_pkg::DATA_BITS-1:0] load_data,
    input  wire logic                            mem_req_valid,
    input  wire logic [fetch_pkg::ADDR_BITS-1:0] mem_req_addr,
    output logic                                 mem_req_ready,
    output logic      [fetch_pkg::DATA_BITS-1:0] mem_req_data
);

    logic [fetch_pkg::DATA_BITS-1:0] mem [2 ** fetch_pkg::ADDR_BITS];

    logic [$clog2(fetch_pkg::MEM_LATENCY + 1)-1:0] wait_cnt;
    logic done; // read answered and valid not yet dropped
    logic fire;

    assign fire = mem_req_valid && !done
        && (wait_cnt == $bits(wait_cnt)'(fetch_pkg::MEM_LATENCY - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wait_cnt <= '0;
            done <= 1'b0;
            mem_req_ready <= 1'b0;
        end
        else
        begin
            mem_req_ready <= fire; // single cycle pulse
            if (!mem_req_valid)
            begin
                wait_cnt <= '0;
                done <= 1'b0;
            end
            else if (fire)
            begin
                wait_cnt <= '0;
                done <= 1'b1;
            end
            else if (!done)
            begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_valid)
        begin
            mem[load_addr] <= load_data;
        end
        if (fire)
        begin
            mem_req_data <= mem[mem_req_addr];
        end
    end

    // program loading and cache fills must not overlap
    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> !load_valid);

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

// shared widths and geometry for the instruction fetch subsystem
package fetch_pkg;

    localparam int ADDR_BITS = 16; // word address
    localparam int DATA_BITS = 32; // one instruction word

    // direct-mapped geometry with one word per line
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;
    localparam int NUM_LINES = 2 ** INDEX_BITS;

    // cycles from a memory read being seen to its ready pulse
    localparam int MEM_LATENCY = 4;

    localparam int COUNT_BITS = 16; // hit and miss counters saturate at all ones

    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        ALLOCATE
    } cache_state_t;

endpackage

`default_nettype wire
